// ==== Makefile ====
# Verilator build and run of the L1 data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l1_dcache
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
logic/cache_pkg.sv
logic/array_if.sv
logic/beat_counter.sv
logic/tag_store.sv
logic/data_store.sv
logic/cache_ctrl.sv
logic/l1_dcache.sv
tb/tb_l1_dcache.sv

// ==== logic/array_if.sv ====
`default_nettype none

interface array_if
    import cache_pkg::*;
();

    // lookup address and selected slot
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic                  way;
    logic [WORD_BITS-1:0]  word;

    logic                  hit;
    logic                  hit_way;
    logic                  victim_way;
    logic                  victim_dirty;
    logic [TAG_BITS-1:0]   victim_tag;

    logic                  tag_fill;
    logic                  mark_dirty;
    logic                  touch;

    // fill_sel picks the l2 beat over the cpu store word
    logic                  data_write;
    logic                  fill_sel;
    line_word_t            fill_data;
    line_word_t            write_word;
    line_word_t            read_word;

    modport ctrl (
        output index, tag, way, word,
        output tag_fill, mark_dirty, touch,
        output data_write, fill_sel, fill_data, write_word,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag,
        input  read_word
    );

    modport tags (
        input  index, tag, way,
        input  tag_fill, mark_dirty, touch,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport data (
        input  index, way, word,
        input  data_write, fill_sel, fill_data, write_word,
        output read_word
    );

endinterface

`default_nettype wire

// ==== logic/beat_counter.sv ====
`default_nettype none

module beat_counter
    import cache_pkg::*;
(
    input  wire                  clk,
    input  wire                  nrst,
    input  wire                  clear,
    input  wire                  step,
    output logic [WORD_BITS-1:0] beat,
    output logic                 last
);

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            beat <= '0;
        else if (clear)
            beat <= '0;
        else if (step)
            beat <= beat + 1'b1;
    end

    // final word of the line is completing
    assign last = step && (beat == WORD_BITS'(WORDS_PER_LINE - 1));

endmodule

`default_nettype wire

// ==== logic/cache_ctrl.sv ====
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
(
    input  wire                  clk,
    input  wire                  nrst,
    input  wire                  req_valid,
    input  wire                  req_write,
    input  wire cache_addr_t     req_addr,
    input  wire line_word_t      req_wdata,
    output logic                 req_ready,
    output logic                 resp_valid,
    output line_word_t           resp_rdata,
    input  wire                  flush,
    output logic                 flush_all,
    output logic                 mem_valid,
    output logic                 mem_write,
    output logic [31:0]          mem_addr,
    output line_word_t           mem_wdata,
    input  wire                  mem_ready,
    input  wire line_word_t      mem_rdata,
    array_if.ctrl                arr,
    input  wire [WORD_BITS-1:0]  beat,
    input  wire                  last,
    output logic                 beat_clear,
    output logic                 beat_step
);

    ctrl_state_t         state;
    ctrl_state_t         next_state;
    cache_addr_t         req_q;
    logic                write_q;
    line_word_t          wdata_q;
    logic                way_q;
    logic [TAG_BITS-1:0] wb_tag_q;
    cache_addr_t         beat_addr;
    logic                accept;

    // no new request while a flush is pending
    assign req_ready = (state == IDLE) && !flush;
    assign flush_all = (state == IDLE) && flush;
    assign accept = req_valid && req_ready;

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
                if (accept)
                    next_state = LOOKUP;
            LOOKUP:
                if (arr.hit)
                    next_state = RESPOND;
                else if (arr.victim_dirty)
                    next_state = WRITE_BACK;
                else
                    next_state = REFILL;
            WRITE_BACK:
                if (last)
                    next_state = REFILL;
            REFILL:
                if (last)
                    next_state = RESPOND;
            RESPOND:
                next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state <= IDLE;
            write_q <= 1'b0;
            way_q <= 1'b0;
            resp_valid <= 1'b0;
        end
        else
        begin
            state <= next_state;
            resp_valid <= (next_state == RESPOND);
            if (accept)
                write_q <= req_write;
            if (state == LOOKUP)
                way_q <= arr.way;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_q <= req_addr;
            wdata_q <= req_wdata;
        end
        // victim tag held for the write-back addresses
        if (state == LOOKUP)
            wb_tag_q <= arr.victim_tag;
    end

    assign mem_valid = (state == WRITE_BACK) || (state == REFILL);
    assign mem_write = (state == WRITE_BACK);
    assign mem_wdata = arr.read_word;
    assign beat_step = mem_valid && mem_ready;
    assign beat_clear = (state == LOOKUP) || ((state == WRITE_BACK) && last);

    always_comb
    begin
        beat_addr.flat = req_q.flat;
        if (state == WRITE_BACK)
            beat_addr.f.tag = wb_tag_q;
        beat_addr.f.word = beat;
        beat_addr.f.byte_off = '0;
    end
    assign mem_addr = beat_addr.flat;

    assign arr.index = req_q.f.index;
    assign arr.tag = req_q.f.tag;
    // way is decided live during lookup, then held
    assign arr.way = (state != LOOKUP) ? way_q :
                     arr.hit ? arr.hit_way : arr.victim_way;
    assign arr.word = mem_valid ? beat : req_q.f.word;

    assign arr.touch = (state == LOOKUP) && arr.hit;
    assign arr.tag_fill = (state == REFILL) && last;
    assign arr.mark_dirty = (state == RESPOND) && write_q;

    // refill beats, then the cpu store in respond
    assign arr.data_write = ((state == REFILL) && beat_step) || arr.mark_dirty;
    assign arr.fill_sel = (state == REFILL);
    assign arr.fill_data = mem_rdata;
    assign arr.write_word = wdata_q;

    assign resp_rdata = arr.read_word;

endmodule

`default_nettype wire

// ==== logic/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // geometry of the 2-way, 32-set cache with 4-word lines
    parameter int INDEX_BITS = 5;
    parameter int WORD_BITS = 2;
    parameter int BYTE_BITS = 2;
    parameter int TAG_BITS = 23;

    parameter int NUM_WAYS = 2;
    parameter int NUM_SETS = 2 ** INDEX_BITS;
    parameter int WORDS_PER_LINE = 2 ** WORD_BITS;

    typedef logic [31:0] line_word_t;

    // cpu byte address split into cache fields
    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [INDEX_BITS-1:0] index;
        logic [WORD_BITS-1:0]  word;
        logic [BYTE_BITS-1:0]  byte_off;
    } addr_fields_t;

    // same address, as a flat word or as fields
    typedef union packed {
        logic [31:0]  flat;
        addr_fields_t f;
    } cache_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        REFILL,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/data_store.sv ====
`default_nettype none

module data_store
    import cache_pkg::*;
(
    input  wire    clk,
    array_if.data  arr
);

    line_word_t lines [NUM_WAYS][NUM_SETS][WORDS_PER_LINE];
    line_word_t wr_data;

    // fill beat from l2 or cpu store word
    assign wr_data = arr.fill_sel ? arr.fill_data : arr.write_word;

    always_ff @(posedge clk)
    begin
        if (arr.data_write)
            lines[arr.way][arr.index][arr.word] <= wr_data;
    end

    // async read off the registered index
    assign arr.read_word = lines[arr.way][arr.index][arr.word];

endmodule

`default_nettype wire

// ==== logic/l1_dcache.sv ====
`default_nettype none

module l1_dcache
    import cache_pkg::*;
(
    input  wire              clk,
    input  wire              nrst,
    input  wire              req_valid,
    output logic             req_ready,
    input  wire              req_write,
    input  wire [31:0]       req_addr,
    input  wire line_word_t  req_wdata,
    output logic             resp_valid,
    output line_word_t       resp_rdata,
    input  wire              flush,
    output logic             mem_valid,
    output logic             mem_write,
    output logic [31:0]      mem_addr,
    output line_word_t       mem_wdata,
    input  wire              mem_ready,
    input  wire line_word_t  mem_rdata
);

    cache_addr_t          req_addr_u;
    logic                 flush_all;
    logic                 beat_clear;
    logic                 beat_step;
    logic                 last;
    logic [WORD_BITS-1:0] beat;

    array_if u_arr ();

    assign req_addr_u = cache_addr_t'(req_addr);

    cache_ctrl u_ctrl (
        .clk        (clk),
        .nrst       (nrst),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr_u),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .flush      (flush),
        .flush_all  (flush_all),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .arr        (u_arr.ctrl),
        .beat       (beat),
        .last       (last),
        .beat_clear (beat_clear),
        .beat_step  (beat_step)
    );

    // flush only reaches the tags once the controller takes it
    tag_store u_tags (
        .clk       (clk),
        .nrst      (nrst),
        .flush_all (flush_all),
        .arr       (u_arr.tags)
    );

    data_store u_data (
        .clk (clk),
        .arr (u_arr.data)
    );

    beat_counter u_beat (
        .clk   (clk),
        .nrst  (nrst),
        .clear (beat_clear),
        .step  (beat_step),
        .beat  (beat),
        .last  (last)
    );

endmodule

`default_nettype wire

// ==== logic/tag_store.sv ====
`default_nettype none

module tag_store
    import cache_pkg::*;
(
    input  wire    clk,
    input  wire    nrst,
    input  wire    flush_all,
    array_if.tags  arr
);

    logic [TAG_BITS-1:0] tags [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid [NUM_WAYS];
    logic [NUM_SETS-1:0] dirty [NUM_WAYS];
    // per set, the way to replace next
    logic [NUM_SETS-1:0] lru;
    logic [NUM_WAYS-1:0] way_hit;
    logic                vic;

    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            way_hit[w] = valid[w][arr.index] && (tags[w][arr.index] == arr.tag);
        end
    end

    assign arr.hit = |way_hit;
    assign arr.hit_way = way_hit[1];

    // empty way first, else lru
    always_comb
    begin
        if (!valid[0][arr.index])
            vic = 1'b0;
        else if (!valid[1][arr.index])
            vic = 1'b1;
        else
            vic = lru[arr.index];
    end

    assign arr.victim_way = vic;
    assign arr.victim_dirty = valid[vic][arr.index] && dirty[vic][arr.index];
    assign arr.victim_tag = tags[vic][arr.index];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '{default: '0};
            dirty <= '{default: '0};
            lru <= '0;
        end
        else if (flush_all)
        begin
            // dirty data is dropped, not written back
            valid <= '{default: '0};
        end
        else
        begin
            if (arr.tag_fill)
            begin
                valid[arr.way][arr.index] <= 1'b1;
                dirty[arr.way][arr.index] <= 1'b0;
            end
            if (arr.mark_dirty)
                dirty[arr.way][arr.index] <= 1'b1;
            if (arr.tag_fill || arr.touch)
                lru[arr.index] <= ~arr.way;
        end
    end

    always_ff @(posedge clk)
    begin
        if (arr.tag_fill)
            tags[arr.way][arr.index] <= arr.tag;
    end

endmodule

`default_nettype wire

// ==== tb/dcache_tests.txt ====
# columns, all hex: op addr wdata expected
# op 0 read, 1 write, 2 flush, 3 l2 check (wdata = write beats, expected = read beats)
# cold read of set 3, then a hit
0 00001034 00000000 5a5a1034
3 00000000 00000000 00000004
0 00001034 00000000 5a5a1034
3 00000000 00000000 00000004
# write hit, read back
1 00001038 cafe0001 00000000
0 00001038 00000000 cafe0001
3 00000000 00000000 00000004
# two more tags in set 3 evict the dirty line
0 00001230 00000000 5a5a1230
0 00001430 00000000 5a5a1430
3 00000000 00000004 0000000c
0 00001038 00000000 cafe0001
0 00001034 00000000 5a5a1034
3 00000000 00000004 00000010
# lru in set 7 with tags 20, 21, 22
0 00004070 00000000 5a5a4070
0 00004274 00000000 5a5a4274
0 0000407c 00000000 5a5a407c
0 00004470 00000000 5a5a4470
0 00004078 00000000 5a5a4078
3 00000000 00000004 0000001c
0 00004270 00000000 5a5a4270
3 00000000 00000004 00000020
# flush, then refills
2 00000000 00000000 00000000
0 00004070 00000000 5a5a4070
0 00001038 00000000 cafe0001
3 00000000 00000004 00000028
# dirty data dropped by flush
1 00004074 12345678 00000000
2 00000000 00000000 00000000
0 00004074 00000000 5a5a4074
3 00000000 00000004 0000002c
# write miss allocates
1 00008000 deadbeef 00000000
0 00008000 00000000 deadbeef
0 00008004 00000000 5a5a8004
3 00000000 00000004 00000030

// ==== tb/tb_l1_dcache.sv ====
`default_nettype none

module tb_l1_dcache;

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk = 1'b0;
    logic        nrst = 1'b0;
    logic        req_valid = 1'b0;
    logic        req_ready;
    logic        req_write = 1'b0;
    logic [31:0] req_addr = '0;
    logic [31:0] req_wdata = '0;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        flush = 1'b0;
    logic        mem_valid;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_ready = 1'b0;
    logic [31:0] mem_rdata = '0;

    // l2 model state
    logic [31:0] l2_mem [logic [31:0]];
    logic [31:0] rng_state = 32'hd56c_a85c;
    logic [1:0]  beat_offset = 2'b00;
    int          read_beats = 0;
    int          write_beats = 0;

    // one entry per test line
    logic [31:0] test_ops [$];
    logic [31:0] test_addrs [$];
    logic [31:0] test_wdata [$];
    logic [31:0] test_expected [$];

    int          cycle_count = 0;
    int          timeout_limit = 64;

    l1_dcache u_l1_dcache (
        .clk        (clk),
        .nrst       (nrst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .flush      (flush),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata)
    );

    always #2 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // untouched words follow the address pattern
    function automatic logic [31:0] l2_read(input logic [31:0] addr);
        if (l2_mem.exists(addr))
            return l2_mem[addr];
        return addr ^ 32'h5a5a_0000;
    endfunction

    // l2 model picks ready and read data for this cycle
    always @(negedge clk)
    begin
        rng_state = xorshift32(rng_state);
        mem_ready = (rng_state[1:0] != 2'b00);
        if (mem_valid && !mem_write)
            mem_rdata = l2_read(mem_addr);
        else
            mem_rdata = '0;
        if (mem_valid && mem_ready)
        begin
            assert (mem_addr[3:2] == beat_offset && mem_addr[1:0] == 2'b00)
            else stop_with_error($sformatf("Fail %0t: beat address 0x%08h, offset %0d expected",
                                           $time, mem_addr, beat_offset));
            beat_offset = beat_offset + 2'b01;
            if (mem_write)
            begin
                l2_mem[mem_addr] = mem_wdata;
                write_beats++;
            end
            else
                read_beats++;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > timeout_limit)
            stop_with_error($sformatf("timeout, the run did not finish in %0d cycles",
                                      timeout_limit));
    end

    task automatic load_tests();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        fd = $fopen("tb/dcache_tests.txt", "r");
        if (fd == 0)
            stop_with_error("could not open tb/dcache_tests.txt");
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() > 0 && line.getc(0) != "#")
            begin
                cnt = $sscanf(line, "%h %h %h %h", op, addr, wdata, expected);
                if (cnt == 4)
                begin
                    test_ops.push_back(op);
                    test_addrs.push_back(addr);
                    test_wdata.push_back(wdata);
                    test_expected.push_back(expected);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_request(input logic wr, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [31:0] expected);
        int cycles;
        int reads0;
        int writes0;
        logic no_traffic;
        reads0 = read_beats;
        writes0 = write_beats;
        req_valid = 1'b1;
        req_write = wr;
        req_addr = addr;
        req_wdata = wdata;
        while (!req_ready)
            @(negedge clk);
        // accepted at the next rising edge
        @(negedge clk);
        req_valid = 1'b0;
        req_write = 1'b0;
        cycles = 1;
        while (!resp_valid)
        begin
            assert (!req_ready)
            else stop_with_error($sformatf("Fail %0t: req_ready high while busy", $time));
            @(negedge clk);
            cycles++;
        end
        assert (!req_ready)
        else stop_with_error($sformatf("Fail %0t: req_ready high with resp_valid", $time));
        if (!wr)
        begin
            assert (resp_rdata === expected)
            else stop_with_error($sformatf("Fail %0t: read 0x%08h got 0x%08h expected 0x%08h",
                                           $time, addr, resp_rdata, expected));
        end
        // hits take exactly two cycles and never touch l2
        no_traffic = (read_beats == reads0) && (write_beats == writes0);
        assert ((cycles == 2) == no_traffic)
        else stop_with_error($sformatf("Fail %0t: 0x%08h took %0d cycles, l2 traffic %0d",
                                       $time, addr, cycles, !no_traffic));
        @(negedge clk);
        assert (!resp_valid)
        else stop_with_error($sformatf("Fail %0t: resp_valid longer than one cycle", $time));
    endtask

    task automatic run_flush();
        flush = 1'b1;
        // req_ready follows flush combinationally
        #1;
        assert (!req_ready)
        else stop_with_error($sformatf("Fail %0t: req_ready high during flush", $time));
        @(negedge clk);
        flush = 1'b0;
        @(negedge clk);
    endtask

    task automatic check_beats(input logic [31:0] exp_writes, input logic [31:0] exp_reads);
        assert (write_beats == int'(exp_writes) && read_beats == int'(exp_reads))
        else stop_with_error($sformatf("Fail %0t: l2 beats %0d writes %0d reads, expected %0d %0d",
                                       $time, write_beats, read_beats, exp_writes, exp_reads));
    endtask

    initial
    begin
        load_tests();
        timeout_limit = test_ops.size() * 64;
        repeat (10) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        assert (req_ready && !resp_valid && !mem_valid && !mem_write)
        else stop_with_error($sformatf("Fail %0t: outputs wrong after reset", $time));
        for (int i = 0; i < test_ops.size(); i++)
        begin
            case (test_ops[i])
                32'd0: run_request(1'b0, test_addrs[i], test_wdata[i], test_expected[i]);
                32'd1: run_request(1'b1, test_addrs[i], test_wdata[i], test_expected[i]);
                32'd2: run_flush();
                32'd3: check_beats(test_wdata[i], test_expected[i]);
                default: stop_with_error("unknown op code in tb/dcache_tests.txt");
            endcase
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
